/* tb.f */
design/decodePkg.sv
design/handshakeSlot.sv
design/immGen.sv
design/ctrlDecode.sv
design/decodeStage.sv
sim/decodeStage_assert.sv
sim/decodeStageTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - design/decodePkg.sv
  - design/handshakeSlot.sv
  - design/immGen.sv
  - design/ctrlDecode.sv
  - design/decodeStage.sv
  - target: simulation
    files:
      - sim/decodeStage_assert.sv
      - sim/decodeStageTb.sv

/* sim/decodeStageTb.sv */
`timescale 1ns/100ps

module decodeStageTb;

    logic               clk = 1'b0;
    logic               rst;
    logic               inReq;
    logic               inAck;
    decodePkg::instrT   instr;
    logic               outReq;
    logic               outAck;
    decodePkg::decodedT decoded;

    logic [31:0]        lcgState = 32'd35097;
    decodePkg::instrT   stimulus[$];
    int                 testCount;
    int                 failedTests;
    int                 errorCount;

    // func3 meaning for base OP / OP-IMM and for the M group
    decodePkg::aluCtrlT baseTable [8] = '{decodePkg::aluAdd, decodePkg::aluSll,
        decodePkg::aluSlt, decodePkg::aluSltu, decodePkg::aluXor, decodePkg::aluSrl,
        decodePkg::aluOr, decodePkg::aluAnd};
    decodePkg::aluCtrlT mulDivTable [8] = '{decodePkg::aluMul, decodePkg::aluMulh,
        decodePkg::aluMulhsu, decodePkg::aluMulhu, decodePkg::aluDiv, decodePkg::aluDivu,
        decodePkg::aluRem, decodePkg::aluRemu};

    decodeStage dut0 (
        .clk     (clk),
        .rst     (rst),
        .inReq   (inReq),
        .inAck   (inAck),
        .instr   (instr),
        .outReq  (outReq),
        .outAck  (outAck),
        .decoded (decoded)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState ^ (lcgState >> 15);
    endfunction

    // Fixed registers rd=3, rs1=4
    function automatic decodePkg::instrT encode(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [2:0] f3, input logic [6:0] op);
        return {f7, rs2, 5'd4, f3, 5'd3, op};
    endfunction

    // Weighted mix with roughly one word in five of raw noise
    function automatic decodePkg::instrT randomInstr();
        logic [31:0]      pick;
        decodePkg::instrT w;
        pick = nextRand() % 16;
        w    = nextRand();
        case (pick)
            0:       w[6:0] = decodePkg::opLui;
            1:       w[6:0] = decodePkg::opAuipc;
            2:       w[6:0] = decodePkg::opJal;
            3:       w = {w[31:15], 3'b000, w[11:7], decodePkg::opJalr};
            4, 5:    w[6:0] = decodePkg::opBranch;
            6:       w[6:0] = decodePkg::opLoad;
            7:       w[6:0] = decodePkg::opStore;
            8, 9:
            begin
                w[6:0] = decodePkg::opImm;
                // Shifts get SLLI, SRLI or SRAI func7
                if (w[13:12] == 2'b01)
                    w[31:25] = {1'b0, w[30], 5'b00000};
            end
            10, 11, 12:
            begin
                w[6:0] = decodePkg::opReg;
                if (w[26])
                    w[31:25] = decodePkg::funct7MulDiv;
                else
                    w[31:25] = {1'b0, w[25], 5'b00000};
            end
            default: ;
        endcase
        return w;
    endfunction

    // Reference model of the decode rules
    function automatic decodePkg::decodedT expectDecode(input decodePkg::instrT w);
        decodePkg::decodedT d;
        logic [5:0]         flags;
        logic               bad;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [31:0]        savedImm;
        logic signed [11:0] immI;
        logic signed [11:0] immS;
        logic signed [12:0] immB;
        logic signed [20:0] immJ;
        d     = '0;
        flags = '0;
        bad   = 1'b0;
        f3    = w[14:12];
        f7    = w[31:25];
        immI  = w[31:20];
        immS  = {w[31:25], w[11:7]};
        immB  = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        // Flag order is aluSrc memRead memWrite regWrite memToReg branch
        case (w[6:0])
            decodePkg::opLui:    {d.aluOp, flags} = {decodePkg::aluOpLui, 6'b100100};
            decodePkg::opAuipc:  {d.aluOp, flags} = {decodePkg::aluOpAuipc, 6'b100100};
            decodePkg::opJal:    {d.aluOp, flags} = {decodePkg::aluOpJal, 6'b100111};
            decodePkg::opJalr:   {d.aluOp, flags} = {decodePkg::aluOpJalr, 6'b100111};
            decodePkg::opBranch: {d.aluOp, flags} = {decodePkg::aluOpBranch, 6'b000001};
            decodePkg::opLoad:   {d.aluOp, flags} = {decodePkg::aluOpMem, 6'b110110};
            decodePkg::opStore:  {d.aluOp, flags} = {decodePkg::aluOpMem, 6'b101000};
            decodePkg::opImm:    {d.aluOp, flags} = {decodePkg::aluOpArith, 6'b100100};
            decodePkg::opReg:    {d.aluOp, flags} = {decodePkg::aluOpArith, 6'b000100};
            default:             bad = 1'b1;
        endcase
        {d.aluSrc, d.memRead, d.memWrite, d.regWrite, d.memToReg, d.branch} = flags;
        case (w[6:0])
            decodePkg::opLui, decodePkg::opAuipc:                d.imm = {w[31:12], 12'h000};
            decodePkg::opLoad, decodePkg::opImm, decodePkg::opJalr: d.imm = immI;
            decodePkg::opStore:                                  d.imm = immS;
            decodePkg::opBranch:                                 d.imm = immB;
            decodePkg::opJal:                                    d.imm = immJ;
            default:                                             d.imm = '0;
        endcase
        d.aluCtrl = decodePkg::aluAdd;
        if (w[6:0] == decodePkg::opJalr && f3 != 3'b000)
            bad = 1'b1;
        if (w[6:0] == decodePkg::opBranch)
        begin
            d.aluCtrl    = decodePkg::aluSub;
            d.branchType = f3;
            bad          = (f3 == 3'b010 || f3 == 3'b011);
        end
        if (w[6:0] == decodePkg::opImm)
        begin
            d.aluCtrl = baseTable[f3];
            if (f3 == 3'b101 && f7 == decodePkg::funct7Alt)
                d.aluCtrl = decodePkg::aluSra;
            else if (f3 == 3'b101 && f7 != decodePkg::funct7Base)
                bad = 1'b1;
        end
        if (w[6:0] == decodePkg::opReg)
        begin
            if (f7 == decodePkg::funct7Base)
                d.aluCtrl = baseTable[f3];
            else if (f7 == decodePkg::funct7MulDiv)
                d.aluCtrl = mulDivTable[f3];
            else if (f7 == decodePkg::funct7Alt && f3 == 3'b000)
                d.aluCtrl = decodePkg::aluSub;
            else if (f7 == decodePkg::funct7Alt && f3 == 3'b101)
                d.aluCtrl = decodePkg::aluSra;
            else
                bad = 1'b1;
        end
        // Illegal words keep only registers and immediate
        if (bad)
        begin
            savedImm  = d.imm;
            d         = '0;
            d.imm     = savedImm;
            d.illegal = 1'b1;
        end
        d.regDest = w[11:7];
        d.rs1     = w[19:15];
        d.rs2     = w[24:20];
        return d;
    endfunction

    task automatic abortRun(input string what);
        $display("timeout: %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic sendInstr(input decodePkg::instrT w);
        int waited;
        waited = 0;
        while (inAck)
        begin
            if (waited == 200)
                abortRun("inAck never dropped before the next request");
            @(posedge clk);
            waited++;
        end
        inReq <= 1'b1;
        instr <= w;
        waited = 0;
        @(posedge clk);
        while (!inAck)
        begin
            if (waited == 200)
                abortRun("inAck never rose for a pending instruction");
            @(posedge clk);
            waited++;
        end
        inReq <= 1'b0;
    endtask

    task automatic receiveBundle(input int delay, output decodePkg::decodedT got);
        int waited;
        waited = 0;
        while (!outReq)
        begin
            if (waited == 200)
                abortRun("outReq never rose for an expected bundle");
            @(posedge clk);
            waited++;
        end
        got = decoded;
        // Downstream stall
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (outReq)
        begin
            if (waited == 200)
                abortRun("outReq stayed high after outAck");
            @(posedge clk);
            waited++;
        end
        outAck <= 1'b0;
    endtask

    task automatic finishTest(input string name, input int items, input int errs);
        testCount++;
        errorCount += errs;
        if (errs != 0)
            failedTests++;
        $display("test %s %0d items, %0d errors", name, items, errs);
    endtask

    task automatic runTest(input string name, input int maxDelay);
        int                 delays[$];
        int                 errs;
        decodePkg::decodedT got;
        decodePkg::decodedT exp;
        errs = 0;
        foreach (stimulus[i])
            delays.push_back(nextRand() % (maxDelay + 1));
        fork
            begin
                foreach (stimulus[i])
                    sendInstr(stimulus[i]);
            end
            begin
                foreach (stimulus[j])
                begin
                    receiveBundle(delays[j], got);
                    exp = expectDecode(stimulus[j]);
                    if (got !== exp)
                    begin
                        errs++;
                        $display("mismatch %s #%0d instr %h: expected %h actual %h",
                                 name, j, stimulus[j], exp, got);
                    end
                end
            end
        join
        finishTest(name, stimulus.size(), errs);
    endtask

    initial
    begin
        decodePkg::instrT w;
        rst         = 1'b1;
        inReq       = 1'b0;
        instr       = '0;
        outAck      = 1'b0;
        testCount   = 0;
        failedTests = 0;
        errorCount  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        if (inAck !== 1'b0 || outReq !== 1'b0)
        begin
            $display("mismatch reset: expected inAck=0 outReq=0 actual inAck=%b outReq=%b",
                     inAck, outReq);
            finishTest("reset", 1, 1);
        end
        else
            finishTest("reset", 1, 0);

        stimulus.delete();
        stimulus.push_back(encode(7'h12, 5'h05, 3'b011, decodePkg::opLui));
        stimulus.push_back(encode(7'h7f, 5'h1f, 3'b111, decodePkg::opAuipc));
        stimulus.push_back(encode(7'h40, 5'h08, 3'b010, decodePkg::opJal));
        stimulus.push_back(encode(7'h7f, 5'h1c, 3'b000, decodePkg::opJalr));
        stimulus.push_back(encode(7'h7f, 5'h02, 3'b000, decodePkg::opBranch));
        stimulus.push_back(encode(7'h01, 5'h02, 3'b101, decodePkg::opBranch));
        stimulus.push_back(encode(7'h02, 5'h10, 3'b010, decodePkg::opLoad));
        stimulus.push_back(encode(7'h7e, 5'h06, 3'b010, decodePkg::opStore));
        stimulus.push_back(encode(7'h05, 5'h11, 3'b000, decodePkg::opImm));
        stimulus.push_back(encode(decodePkg::funct7Base, 5'h03, 3'b101, decodePkg::opImm));
        stimulus.push_back(encode(decodePkg::funct7Alt, 5'h03, 3'b101, decodePkg::opImm));
        stimulus.push_back(encode(decodePkg::funct7Base, 5'h05, 3'b000, decodePkg::opReg));
        stimulus.push_back(encode(decodePkg::funct7Alt, 5'h05, 3'b000, decodePkg::opReg));
        stimulus.push_back(encode(decodePkg::funct7Base, 5'h05, 3'b101, decodePkg::opReg));
        stimulus.push_back(encode(decodePkg::funct7Alt, 5'h05, 3'b101, decodePkg::opReg));
        stimulus.push_back(encode(decodePkg::funct7Base, 5'h05, 3'b111, decodePkg::opReg));
        runTest("directed", 3);

        // Sign bit forced so every immediate is negative
        stimulus.delete();
        for (int i = 0; i < 40; i++)
        begin
            w = nextRand() | 32'h8000_0000;
            case (i % 5)
                0:       w[6:0] = decodePkg::opLoad;
                1:       w[6:0] = decodePkg::opStore;
                2:       w[6:0] = decodePkg::opBranch;
                3:       w[6:0] = decodePkg::opJal;
                default: w[6:0] = decodePkg::opLui;
            endcase
            stimulus.push_back(w);
        end
        runTest("immediates", 3);

        stimulus.delete();
        for (int i = 0; i < 8; i++)
            stimulus.push_back(encode(decodePkg::funct7MulDiv, 5'h06, i[2:0], decodePkg::opReg));
        runTest("muldiv", 3);

        stimulus.delete();
        stimulus.push_back(32'h0000_0073);
        stimulus.push_back(32'h0010_0073);
        stimulus.push_back(32'h0ff0_000f);
        stimulus.push_back(encode(7'h00, 5'h05, 3'b000, 7'b1111111));
        stimulus.push_back(encode(decodePkg::funct7Alt, 5'h05, 3'b001, decodePkg::opReg));
        stimulus.push_back(encode(7'h10, 5'h05, 3'b000, decodePkg::opReg));
        stimulus.push_back(encode(7'h00, 5'h05, 3'b001, decodePkg::opJalr));
        stimulus.push_back(encode(7'h00, 5'h05, 3'b010, decodePkg::opBranch));
        stimulus.push_back(encode(decodePkg::funct7MulDiv, 5'h05, 3'b101, decodePkg::opImm));
        runTest("illegal", 3);

        stimulus.delete();
        for (int i = 0; i < 300; i++)
            stimulus.push_back(randomInstr());
        runTest("random_stream", 7);

        $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
                 testCount, failedTests, errorCount, dut0.assert0.failCount);
        if (failedTests == 0 && dut0.assert0.failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* sim/decodeStage_assert.sv */
`timescale 1ns/100ps

module decodeStageAssert (
    input logic               clk,
    input logic               rst,
    input logic               inReq,
    input logic               inAck,
    input logic               outReq,
    input logic               outAck,
    input decodePkg::decodedT decoded
);

    int failCount = 0;

    // A new request waits until the previous ack has fallen
    inReqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(inReq) |-> !inAck)
        else
        begin
            $error("inReq rose while inAck was still high");
            failCount++;
        end

    outReqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(outReq) |-> !outAck)
        else
        begin
            $error("outReq rose while outAck was still high");
            failCount++;
        end

    // Ack only answers a request
    inAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(inAck) |-> $past(inReq))
        else
        begin
            $error("inAck rose without inReq");
            failCount++;
        end

    outAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(outAck) |-> $past(outReq))
        else
        begin
            $error("outAck rose without outReq");
            failCount++;
        end

    decodedHeld: assert property (@(posedge clk) disable iff (rst)
        outReq && !outAck |=> $stable(decoded))
        else
        begin
            $error("decoded changed while the bundle was offered");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) rst |=> !inAck && !outReq)
        else
        begin
            $error("inAck or outReq high during reset");
            failCount++;
        end

endmodule

bind decodeStage decodeStageAssert assert0 (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inAck   (inAck),
    .outReq  (outReq),
    .outAck  (outAck),
    .decoded (decoded)
);

/* design/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage (
    input  logic               clk,
    input  logic               rst,

    input  logic               inReq,
    output logic               inAck,
    input  decodePkg::instrT   instr,

    output logic               outReq,
    input  logic               outAck,
    output decodePkg::decodedT decoded
);

    decodePkg::instrT           heldInstr;
    logic                       midReq;
    logic                       midAck;
    logic [decodePkg::xlen-1:0] imm;
    decodePkg::decodedT         ctrl;
    decodePkg::decodedT         bundle;

    // Instruction word holding slot
    handshakeSlot #(
        .payloadT (decodePkg::instrT)
    ) inSlot (
        .clk     (clk),
        .rst     (rst),
        .inReq   (inReq),
        .inAck   (inAck),
        .inData  (instr),
        .outReq  (midReq),
        .outAck  (midAck),
        .outData (heldInstr)
    );

    immGen immGen0 (
        .instr (heldInstr),
        .imm   (imm)
    );

    ctrlDecode ctrlDecode0 (
        .instr (heldInstr),
        .ctrl  (ctrl)
    );

    // Immediate goes into the otherwise complete control bundle
    always_comb
    begin
        bundle     = ctrl;
        bundle.imm = imm;
    end

    // Decoded bundle holding slot
    handshakeSlot #(
        .payloadT (decodePkg::decodedT)
    ) outSlot (
        .clk     (clk),
        .rst     (rst),
        .inReq   (midReq),
        .inAck   (midAck),
        .inData  (bundle),
        .outReq  (outReq),
        .outAck  (outAck),
        .outData (decoded)
    );

endmodule

/* design/ctrlDecode.sv */
`timescale 1ns/100ps

module ctrlDecode (
    input  decodePkg::instrT   instr,
    output decodePkg::decodedT ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       isIllegal;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];

    // Shared func3 map of OP-IMM and base OP, right shift defaults to logical
    function automatic decodePkg::aluCtrlT baseAluCtrl(input logic [2:0] f3);
        decodePkg::aluCtrlT code;
        case (f3)
            3'b000:  code = decodePkg::aluAdd;
            3'b001:  code = decodePkg::aluSll;
            3'b010:  code = decodePkg::aluSlt;
            3'b011:  code = decodePkg::aluSltu;
            3'b100:  code = decodePkg::aluXor;
            3'b101:  code = decodePkg::aluSrl;
            3'b110:  code = decodePkg::aluOr;
            default: code = decodePkg::aluAnd;
        endcase
        return code;
    endfunction

    always_comb
    begin
        ctrl      = '0;
        isIllegal = 1'b0;

        case (opcode)
            decodePkg::opLui:
            begin
                ctrl.aluOp    = decodePkg::aluOpLui;
                ctrl.aluCtrl  = decodePkg::aluAdd;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            decodePkg::opAuipc:
            begin
                ctrl.aluOp    = decodePkg::aluOpAuipc;
                ctrl.aluCtrl  = decodePkg::aluAdd;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            // Jumps write the link address to rd
            decodePkg::opJal,
            decodePkg::opJalr:
            begin
                ctrl.aluOp    = (opcode == decodePkg::opJal) ? decodePkg::aluOpJal
                                                             : decodePkg::aluOpJalr;
                ctrl.aluCtrl  = decodePkg::aluAdd;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.branch   = 1'b1;
                if (opcode == decodePkg::opJalr && func3 != 3'b000)
                    isIllegal = 1'b1;
            end

            // Compare by subtraction, 010 and 011 are unassigned
            decodePkg::opBranch:
            begin
                ctrl.aluOp      = decodePkg::aluOpBranch;
                ctrl.aluCtrl    = decodePkg::aluSub;
                ctrl.branch     = 1'b1;
                ctrl.branchType = func3;
                if (func3 == 3'b010 || func3 == 3'b011)
                    isIllegal = 1'b1;
            end

            decodePkg::opLoad:
            begin
                ctrl.aluOp    = decodePkg::aluOpMem;
                ctrl.aluCtrl  = decodePkg::aluAdd;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            decodePkg::opStore:
            begin
                ctrl.aluOp    = decodePkg::aluOpMem;
                ctrl.aluCtrl  = decodePkg::aluAdd;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end

            decodePkg::opImm:
            begin
                ctrl.aluOp    = decodePkg::aluOpArith;
                ctrl.aluCtrl  = baseAluCtrl(func3);
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                // SRAI vs SRLI
                if (func3 == 3'b101)
                begin
                    if (func7 == decodePkg::funct7Alt)
                        ctrl.aluCtrl = decodePkg::aluSra;
                    else if (func7 != decodePkg::funct7Base)
                        isIllegal = 1'b1;
                end
            end

            decodePkg::opReg:
            begin
                ctrl.aluOp    = decodePkg::aluOpArith;
                ctrl.regWrite = 1'b1;
                case (func7)
                    decodePkg::funct7Base:
                        ctrl.aluCtrl = baseAluCtrl(func3);
                    decodePkg::funct7Alt:
                        if (func3 == 3'b000)
                            ctrl.aluCtrl = decodePkg::aluSub;
                        else if (func3 == 3'b101)
                            ctrl.aluCtrl = decodePkg::aluSra;
                        else
                            isIllegal = 1'b1;
                    // MUL through REMU follow func3 in order
                    decodePkg::funct7MulDiv:
                        ctrl.aluCtrl = decodePkg::aluMul + {2'b00, func3};
                    default:
                        isIllegal = 1'b1;
                endcase
            end

            // SYSTEM, FENCE and anything unknown
            default:
                isIllegal = 1'b1;
        endcase

        if (isIllegal)
        begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end

        // Register fields pass through for every word
        ctrl.regDest = instr[11:7];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
    end

endmodule

/* design/immGen.sv */
`timescale 1ns/100ps

module immGen (
    input  decodePkg::instrT             instr,
    output logic [decodePkg::xlen-1:0]   imm
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb
    begin
        case (opcode)
            // U-type
            decodePkg::opLui,
            decodePkg::opAuipc:
                imm = {instr[31:12], 12'b0};

            // I-type
            decodePkg::opLoad,
            decodePkg::opImm,
            decodePkg::opJalr:
                imm = {{20{instr[31]}}, instr[31:20]};

            // S-type
            decodePkg::opStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

            // B-type, offset in halfwords
            decodePkg::opBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};

            // J-type
            decodePkg::opJal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};

            // R-type and unknown opcodes carry no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

/* design/handshakeSlot.sv */
`timescale 1ns/100ps

module handshakeSlot #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    inReq,
    output logic    inAck,
    input  payloadT inData,

    output logic    outReq,
    input  logic    outAck,
    output payloadT outData
);

    typedef enum logic {inIdle, inAcked} inStateT;
    typedef enum logic [1:0] {outEmpty, outOffered, outDraining} outStateT;

    inStateT  inState;
    outStateT outState;
    logic     full;
    logic     capture;
    payloadT  payload;

    // Take a new word only with ack low and nothing held
    assign capture = (inState == inIdle) && inReq && !full;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            inState <= inIdle;
        end
        else
        begin
            case (inState)
                inIdle:
                    if (capture)
                        inState <= inAcked;
                inAcked:
                    if (!inReq)
                        inState <= inIdle;
                default:
                    inState <= inIdle;
            endcase
        end
    end

    // Downstream side, offered one cycle after capture
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            outState <= outEmpty;
        end
        else
        begin
            case (outState)
                outEmpty:
                    if (full)
                        outState <= outOffered;
                outOffered:
                    if (outAck)
                        outState <= outDraining;
                outDraining:
                    if (!outAck)
                        outState <= outEmpty;
                default:
                    outState <= outEmpty;
            endcase
        end
    end

    // Slot frees up once the downstream ack has fallen
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            full <= 1'b0;
        else if (capture)
            full <= 1'b1;
        else if (outState == outDraining && !outAck)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            payload <= inData;
    end

    assign inAck   = (inState == inAcked);
    assign outReq  = (outState == outOffered);
    assign outData = payload;

endmodule

/* design/decodePkg.sv */
package decodePkg;

    // Datapath width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] instrT;
    typedef logic [4:0]      regAddrT;

    // RV32 major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // func7 variants within OP and the shift-immediate group
    localparam logic [6:0] funct7Base   = 7'b0000000;
    localparam logic [6:0] funct7Alt    = 7'b0100000;
    localparam logic [6:0] funct7MulDiv = 7'b0000001;

    // Operation class seen by the execute stage
    typedef logic [2:0] aluOpT;

    localparam aluOpT aluOpMem    = 3'b000;
    localparam aluOpT aluOpBranch = 3'b001;
    localparam aluOpT aluOpArith  = 3'b010;
    localparam aluOpT aluOpJal    = 3'b011;
    localparam aluOpT aluOpLui    = 3'b100;
    localparam aluOpT aluOpAuipc  = 3'b101;
    localparam aluOpT aluOpJalr   = 3'b111;

    // Exact ALU operation
    typedef logic [4:0] aluCtrlT;

    localparam aluCtrlT aluAnd  = 5'd0;
    localparam aluCtrlT aluOr   = 5'd1;
    localparam aluCtrlT aluAdd  = 5'd2;
    localparam aluCtrlT aluXor  = 5'd3;
    localparam aluCtrlT aluSub  = 5'd4;
    localparam aluCtrlT aluSll  = 5'd6;
    localparam aluCtrlT aluSrl  = 5'd7;
    localparam aluCtrlT aluSra  = 5'd8;
    localparam aluCtrlT aluSlt  = 5'd9;
    localparam aluCtrlT aluSltu = 5'd10;

    // M extension, consecutive so func3 can be added to aluMul
    localparam aluCtrlT aluMul    = 5'd11;
    localparam aluCtrlT aluMulh   = 5'd12;
    localparam aluCtrlT aluMulhsu = 5'd13;
    localparam aluCtrlT aluMulhu  = 5'd14;
    localparam aluCtrlT aluDiv    = 5'd15;
    localparam aluCtrlT aluDivu   = 5'd16;
    localparam aluCtrlT aluRem    = 5'd17;
    localparam aluCtrlT aluRemu   = 5'd18;

    // Decoded control bundle handed to the execute stage
    typedef struct packed {
        aluOpT           aluOp;
        aluCtrlT         aluCtrl;

        // Operand B comes from imm when set
        logic            aluSrc;
        logic            memRead;
        logic            memWrite;
        logic            regWrite;
        logic            memToReg;
        logic            branch;

        // func3 of a branch, zero elsewhere
        logic [2:0]      branchType;

        regAddrT         regDest;
        regAddrT         rs1;
        regAddrT         rs2;

        logic [xlen-1:0] imm;

        logic            illegal;
    } decodedT;

endpackage
